//--- common/ao_periph_pkg.sv
// Always-on peripheral subsystem definitions
// Address map, register offsets, widths and the peripheral select code

`default_nettype none

package ao_periph_pkg;

  // Bus and register widths
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned BE_W        = 4;
  localparam int unsigned REG_OFFS_W  = 6;
  localparam int unsigned FAST_INTR_W = 15;
  localparam int unsigned GPIO_W      = 8;

  // Peripheral base addresses, bits 11:8 pick the target
  localparam logic [31:0] SOC_CTRL_BASE  = 32'h0000_0000;
  localparam logic [31:0] FAST_INTR_BASE = 32'h0000_0100;
  localparam logic [31:0] GPIO_BASE      = 32'h0000_0200;
  localparam logic [31:0] TIMER_BASE     = 32'h0000_0300;

  // SoC control word offsets
  localparam logic [REG_OFFS_W-1:0] SOC_EXIT_VALID = 6'd0;
  localparam logic [REG_OFFS_W-1:0] SOC_EXIT_VALUE = 6'd1;
  localparam logic [REG_OFFS_W-1:0] SOC_BOOT_SEL   = 6'd2;

  // Fast interrupt controller word offsets
  localparam logic [REG_OFFS_W-1:0] FI_PENDING = 6'd0;
  localparam logic [REG_OFFS_W-1:0] FI_ENABLE  = 6'd1;

  // GPIO word offsets
  localparam logic [REG_OFFS_W-1:0] GPIO_OUT     = 6'd0;
  localparam logic [REG_OFFS_W-1:0] GPIO_EN      = 6'd1;
  localparam logic [REG_OFFS_W-1:0] GPIO_IN      = 6'd2;
  localparam logic [REG_OFFS_W-1:0] GPIO_INTR_EN = 6'd3;

  // Timer word offsets
  localparam logic [REG_OFFS_W-1:0] TMR_MTIME = 6'd0;
  localparam logic [REG_OFFS_W-1:0] TMR_CMP   = 6'd1;
  localparam logic [REG_OFFS_W-1:0] TMR_CTRL  = 6'd2;

  typedef enum logic [2:0] {
    SEL_SOC_CTRL  = 3'd0,
    SEL_FAST_INTR = 3'd1,
    SEL_GPIO      = 3'd2,
    SEL_TIMER     = 3'd3,
    SEL_NONE      = 3'd4
  } periph_sel_e;

  // Expands byte enables into a bit mask over the data word
  function automatic logic [DATA_W-1:0] be_mask(input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] mask;
    for (int i = 0; i < BE_W; i++) begin
      mask[i*8 +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

//--- hw/periph_bus_ctrl/periph_bus_ctrl.sv
// Peripheral bus controller
// Decodes the address, steers register strobes and returns a one-cycle response

`default_nettype none

module periph_bus_ctrl
  import ao_periph_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,

  input  wire logic              req_i,
  input  wire logic [31:0]       addr_i,
  input  wire logic              we_i,
  input  wire logic [BE_W-1:0]   be_i,
  input  wire logic [DATA_W-1:0] wdata_i,

  input  wire logic [DATA_W-1:0] soc_rdata_i,
  input  wire logic [DATA_W-1:0] fi_rdata_i,
  input  wire logic [DATA_W-1:0] gpio_rdata_i,
  input  wire logic [DATA_W-1:0] tmr_rdata_i,

  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [DATA_W-1:0]      rdata_o,
  output logic                   err_o,

  output logic                   soc_we_o,
  output logic                   fi_we_o,
  output logic                   gpio_we_o,
  output logic                   tmr_we_o,
  output logic                   soc_re_o,
  output logic                   fi_re_o,
  output logic                   gpio_re_o,
  output logic                   tmr_re_o,
  output logic [REG_OFFS_W-1:0]  reg_offs_o,
  output logic [DATA_W-1:0]      reg_wdata_o,
  output logic [BE_W-1:0]        reg_be_o
);

  periph_sel_e       sel;
  logic [DATA_W-1:0] rdata_mux;
  logic              wr, rd;
  logic              rvalid_q, err_q;
  logic [DATA_W-1:0] rdata_q;

  // Anything above 4 KiB is unmapped
  always_comb begin
    sel = SEL_NONE;
    if (addr_i[31:12] == '0) begin
      case (addr_i[11:8])
        SOC_CTRL_BASE[11:8]:  sel = SEL_SOC_CTRL;
        FAST_INTR_BASE[11:8]: sel = SEL_FAST_INTR;
        GPIO_BASE[11:8]:      sel = SEL_GPIO;
        TIMER_BASE[11:8]:     sel = SEL_TIMER;
        default:              sel = SEL_NONE;
      endcase
    end
  end

  // No back-pressure
  assign gnt_o = req_i;

  assign wr = req_i & we_i;
  assign rd = req_i & ~we_i;

  assign soc_we_o  = wr & (sel == SEL_SOC_CTRL);
  assign fi_we_o   = wr & (sel == SEL_FAST_INTR);
  assign gpio_we_o = wr & (sel == SEL_GPIO);
  assign tmr_we_o  = wr & (sel == SEL_TIMER);
  assign soc_re_o  = rd & (sel == SEL_SOC_CTRL);
  assign fi_re_o   = rd & (sel == SEL_FAST_INTR);
  assign gpio_re_o = rd & (sel == SEL_GPIO);
  assign tmr_re_o  = rd & (sel == SEL_TIMER);

  assign reg_offs_o  = addr_i[7:2];
  assign reg_wdata_o = wdata_i;
  assign reg_be_o    = be_i;

  // Peripherals drive zero unless read-strobed, so writes return zero data
  always_comb begin
    case (sel)
      SEL_SOC_CTRL:  rdata_mux = soc_rdata_i;
      SEL_FAST_INTR: rdata_mux = fi_rdata_i;
      SEL_GPIO:      rdata_mux = gpio_rdata_i;
      SEL_TIMER:     rdata_mux = tmr_rdata_i;
      default:       rdata_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i & (sel == SEL_NONE);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rdata_mux;
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;
  assign rdata_o  = rdata_q;

  a_one_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({soc_we_o, fi_we_o, gpio_we_o, tmr_we_o,
              soc_re_o, fi_re_o, gpio_re_o, tmr_re_o}));

  // Every granted request gets exactly one response a cycle later
  a_rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_o == $past(req_i));

endmodule : periph_bus_ctrl

`default_nettype wire

//--- hw/soc_ctrl/soc_ctrl.sv
// SoC control registers
// Exit value and exit valid for the host, plus boot select status

`default_nettype none

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,

  input  wire logic                  reg_we_i,
  input  wire logic                  reg_re_i,
  input  wire logic [REG_OFFS_W-1:0] reg_offs_i,
  input  wire logic [DATA_W-1:0]     reg_wdata_i,
  input  wire logic [BE_W-1:0]       reg_be_i,
  output logic [DATA_W-1:0]          reg_rdata_o,

  input  wire logic                  boot_select_i,
  output logic                       exit_valid_o,
  output logic [DATA_W-1:0]          exit_value_o
);

  logic [DATA_W-1:0] wmask;
  logic [DATA_W-1:0] exit_value_q;
  logic              exit_valid_q;

  assign wmask = be_mask(reg_be_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (reg_we_i) begin
      if (reg_offs_i == SOC_EXIT_VALID) begin
        exit_valid_q <= (exit_valid_q & ~wmask[0]) | (reg_wdata_i[0] & wmask[0]);
      end
      if (reg_offs_i == SOC_EXIT_VALUE) begin
        exit_value_q <= (exit_value_q & ~wmask) | (reg_wdata_i & wmask);
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    if (reg_re_i) begin
      case (reg_offs_i)
        SOC_EXIT_VALID: reg_rdata_o = {{(DATA_W-1){1'b0}}, exit_valid_q};
        SOC_EXIT_VALUE: reg_rdata_o = exit_value_q;
        SOC_BOOT_SEL:   reg_rdata_o = {{(DATA_W-1){1'b0}}, boot_select_i};
        default:        reg_rdata_o = '0;
      endcase
    end
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

`default_nettype wire

//--- hw/fast_intr_ctrl/fast_intr_ctrl.sv
// Fast interrupt controller
// Latches 15 interrupt lines as pending and masks them with an enable

`default_nettype none

module fast_intr_ctrl
  import ao_periph_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,

  input  wire logic                   reg_we_i,
  input  wire logic                   reg_re_i,
  input  wire logic [REG_OFFS_W-1:0]  reg_offs_i,
  input  wire logic [DATA_W-1:0]      reg_wdata_i,
  input  wire logic [BE_W-1:0]        reg_be_i,
  output logic [DATA_W-1:0]           reg_rdata_o,

  input  wire logic [FAST_INTR_W-1:0] fast_intr_i,
  output logic [FAST_INTR_W-1:0]      fast_intr_o
);

  logic [DATA_W-1:0]      wmask;
  logic [FAST_INTR_W-1:0] pending_q, enable_q;
  logic [FAST_INTR_W-1:0] clr;

  assign wmask = be_mask(reg_be_i);

  // Write one to clear
  assign clr = (reg_we_i && reg_offs_i == FI_PENDING) ?
               (reg_wdata_i[FAST_INTR_W-1:0] & wmask[FAST_INTR_W-1:0]) : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // Incoming level wins over a clear in the same cycle
      pending_q <= (pending_q & ~clr) | fast_intr_i;
      if (reg_we_i && reg_offs_i == FI_ENABLE) begin
        enable_q <= (enable_q & ~wmask[FAST_INTR_W-1:0]) |
                    (reg_wdata_i[FAST_INTR_W-1:0] & wmask[FAST_INTR_W-1:0]);
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    if (reg_re_i) begin
      case (reg_offs_i)
        FI_PENDING: reg_rdata_o = {{(DATA_W-FAST_INTR_W){1'b0}}, pending_q};
        FI_ENABLE:  reg_rdata_o = {{(DATA_W-FAST_INTR_W){1'b0}}, enable_q};
        default:    reg_rdata_o = '0;
      endcase
    end
  end

  assign fast_intr_o = pending_q & enable_q;

  a_masked_intr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (fast_intr_o & ~enable_q) == '0);

endmodule : fast_intr_ctrl

`default_nettype wire

//--- hw/gpio/gpio.sv
// 8-bit GPIO
// Output and output enable registers, synchronised input, level interrupts

`default_nettype none

module gpio
  import ao_periph_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,

  input  wire logic                  reg_we_i,
  input  wire logic                  reg_re_i,
  input  wire logic [REG_OFFS_W-1:0] reg_offs_i,
  input  wire logic [DATA_W-1:0]     reg_wdata_i,
  input  wire logic [BE_W-1:0]       reg_be_i,
  output logic [DATA_W-1:0]          reg_rdata_o,

  input  wire logic [GPIO_W-1:0]     cio_gpio_i,
  output logic [GPIO_W-1:0]          cio_gpio_o,
  output logic [GPIO_W-1:0]          cio_gpio_en_o,
  output logic [GPIO_W-1:0]          intr_gpio_o
);

  logic [DATA_W-1:0] wmask;
  logic [GPIO_W-1:0] bmask, bdata;
  logic [GPIO_W-1:0] out_q, en_q, intr_en_q;
  logic [GPIO_W-1:0] in_meta_q, in_sync_q;

  assign wmask = be_mask(reg_be_i);
  assign bmask = wmask[GPIO_W-1:0];
  assign bdata = reg_wdata_i[GPIO_W-1:0] & bmask;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
    end else if (reg_we_i) begin
      case (reg_offs_i)
        GPIO_OUT:     out_q     <= (out_q & ~bmask) | bdata;
        GPIO_EN:      en_q      <= (en_q & ~bmask) | bdata;
        GPIO_INTR_EN: intr_en_q <= (intr_en_q & ~bmask) | bdata;
        default:      ;
      endcase
    end
  end

  // Two-flop synchroniser on the pads
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= cio_gpio_i;
      in_sync_q <= in_meta_q;
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    if (reg_re_i) begin
      case (reg_offs_i)
        GPIO_OUT:     reg_rdata_o = {{(DATA_W-GPIO_W){1'b0}}, out_q};
        GPIO_EN:      reg_rdata_o = {{(DATA_W-GPIO_W){1'b0}}, en_q};
        GPIO_IN:      reg_rdata_o = {{(DATA_W-GPIO_W){1'b0}}, in_sync_q};
        GPIO_INTR_EN: reg_rdata_o = {{(DATA_W-GPIO_W){1'b0}}, intr_en_q};
        default:      reg_rdata_o = '0;
      endcase
    end
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = en_q;
  assign intr_gpio_o   = in_sync_q & intr_en_q;

endmodule : gpio

`default_nettype wire

//--- hw/timer/timer.sv
// Machine timer
// Free-running 32-bit counter with a level compare interrupt

`default_nettype none

module timer
  import ao_periph_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,

  input  wire logic                  reg_we_i,
  input  wire logic                  reg_re_i,
  input  wire logic [REG_OFFS_W-1:0] reg_offs_i,
  input  wire logic [DATA_W-1:0]     reg_wdata_i,
  input  wire logic [BE_W-1:0]       reg_be_i,
  output logic [DATA_W-1:0]          reg_rdata_o,

  output logic                       timer_intr_o
);

  logic [DATA_W-1:0] wmask;
  logic [DATA_W-1:0] mtime_q, cmp_q;
  logic              en_q;

  assign wmask = be_mask(reg_be_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q <= '0;
      cmp_q   <= '0;
      en_q    <= 1'b0;
    end else begin
      // A write to MTIME loads the count instead of incrementing
      if (reg_we_i && reg_offs_i == TMR_MTIME) begin
        mtime_q <= (mtime_q & ~wmask) | (reg_wdata_i & wmask);
      end else if (en_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (reg_we_i && reg_offs_i == TMR_CMP) begin
        cmp_q <= (cmp_q & ~wmask) | (reg_wdata_i & wmask);
      end
      if (reg_we_i && reg_offs_i == TMR_CTRL) begin
        en_q <= (en_q & ~wmask[0]) | (reg_wdata_i[0] & wmask[0]);
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    if (reg_re_i) begin
      case (reg_offs_i)
        TMR_MTIME: reg_rdata_o = mtime_q;
        TMR_CMP:   reg_rdata_o = cmp_q;
        TMR_CTRL:  reg_rdata_o = {{(DATA_W-1){1'b0}}, en_q};
        default:   reg_rdata_o = '0;
      endcase
    end
  end

  assign timer_intr_o = en_q & (mtime_q >= cmp_q);

  a_intr_needs_en: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    timer_intr_o |-> en_q);

endmodule : timer

`default_nettype wire

//--- hw/ao_periph_subsys.sv
// Always-on peripheral subsystem
// Bus controller in front of SoC control, fast interrupts, GPIO and timer

`default_nettype none

module ao_periph_subsys
  import ao_periph_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,

  // Bus slave port
  input  wire logic                   req_i,
  input  wire logic [31:0]            addr_i,
  input  wire logic                   we_i,
  input  wire logic [BE_W-1:0]        be_i,
  input  wire logic [DATA_W-1:0]      wdata_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output logic [DATA_W-1:0]           rdata_o,
  output logic                        err_o,

  // SoC control
  input  wire logic                   boot_select_i,
  output logic                        exit_valid_o,
  output logic [DATA_W-1:0]           exit_value_o,

  // Fast interrupts
  input  wire logic [FAST_INTR_W-1:0] fast_intr_i,
  output logic [FAST_INTR_W-1:0]      fast_intr_o,

  // GPIO
  input  wire logic [GPIO_W-1:0]      cio_gpio_i,
  output logic [GPIO_W-1:0]           cio_gpio_o,
  output logic [GPIO_W-1:0]           cio_gpio_en_o,
  output logic [GPIO_W-1:0]           intr_gpio_o,

  // Timer
  output logic                        timer_intr_o
);

  logic                  soc_we, fi_we, gpio_we, tmr_we;
  logic                  soc_re, fi_re, gpio_re, tmr_re;
  logic [REG_OFFS_W-1:0] reg_offs;
  logic [DATA_W-1:0]     reg_wdata;
  logic [BE_W-1:0]       reg_be;
  logic [DATA_W-1:0]     soc_rdata, fi_rdata, gpio_rdata, tmr_rdata;

  periph_bus_ctrl i_periph_bus_ctrl (
    .clk_i,
    .arst_n_i,
    .req_i,
    .addr_i,
    .we_i,
    .be_i,
    .wdata_i,
    .soc_rdata_i  (soc_rdata),
    .fi_rdata_i   (fi_rdata),
    .gpio_rdata_i (gpio_rdata),
    .tmr_rdata_i  (tmr_rdata),
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .err_o,
    .soc_we_o     (soc_we),
    .fi_we_o      (fi_we),
    .gpio_we_o    (gpio_we),
    .tmr_we_o     (tmr_we),
    .soc_re_o     (soc_re),
    .fi_re_o      (fi_re),
    .gpio_re_o    (gpio_re),
    .tmr_re_o     (tmr_re),
    .reg_offs_o   (reg_offs),
    .reg_wdata_o  (reg_wdata),
    .reg_be_o     (reg_be)
  );

  soc_ctrl i_soc_ctrl (
    .clk_i,
    .arst_n_i,
    .reg_we_i    (soc_we),
    .reg_re_i    (soc_re),
    .reg_offs_i  (reg_offs),
    .reg_wdata_i (reg_wdata),
    .reg_be_i    (reg_be),
    .reg_rdata_o (soc_rdata),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl i_fast_intr_ctrl (
    .clk_i,
    .arst_n_i,
    .reg_we_i    (fi_we),
    .reg_re_i    (fi_re),
    .reg_offs_i  (reg_offs),
    .reg_wdata_i (reg_wdata),
    .reg_be_i    (reg_be),
    .reg_rdata_o (fi_rdata),
    .fast_intr_i,
    .fast_intr_o
  );

  gpio i_gpio (
    .clk_i,
    .arst_n_i,
    .reg_we_i    (gpio_we),
    .reg_re_i    (gpio_re),
    .reg_offs_i  (reg_offs),
    .reg_wdata_i (reg_wdata),
    .reg_be_i    (reg_be),
    .reg_rdata_o (gpio_rdata),
    .cio_gpio_i,
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

  timer i_timer (
    .clk_i,
    .arst_n_i,
    .reg_we_i    (tmr_we),
    .reg_re_i    (tmr_re),
    .reg_offs_i  (reg_offs),
    .reg_wdata_i (reg_wdata),
    .reg_be_i    (reg_be),
    .reg_rdata_o (tmr_rdata),
    .timer_intr_o
  );

endmodule : ao_periph_subsys

`default_nettype wire

//--- verif/tb_checker.sv
// Bus and pin monitor for the always-on peripheral subsystem
// Shadows every register, predicts responses and compares port levels

`default_nettype none

module tb_checker
  import ao_periph_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        arst_n_i,
  input  wire logic        req_i,
  input  wire logic [31:0] addr_i,
  input  wire logic        we_i,
  input  wire logic [3:0]  be_i,
  input  wire logic [31:0] wdata_i,
  input  wire logic        gnt_i,
  input  wire logic        rvalid_i,
  input  wire logic [31:0] rdata_i,
  input  wire logic        err_i,
  input  wire logic        boot_select_i,
  input  wire logic        exit_valid_i,
  input  wire logic [31:0] exit_value_i,
  input  wire logic [14:0] fast_intr_i,
  input  wire logic [14:0] fast_intr_out_i,
  input  wire logic [7:0]  cio_gpio_i,
  input  wire logic [7:0]  cio_gpio_out_i,
  input  wire logic [7:0]  cio_gpio_en_i,
  input  wire logic [7:0]  intr_gpio_i,
  input  wire logic        timer_intr_i,
  output int               err_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int          errors = 0;
  logic [31:0] sh_exit_value, sh_cmp;
  logic        sh_exit_valid, sh_tmr_en, intr_seen;
  logic [14:0] sh_pending, sh_fi_en, clr;
  logic [7:0]  sh_out, sh_oe, sh_intr_en, sync1, sync2;
  // Request taken at the previous edge, answered at this one
  logic        rsp_pend, rsp_we;
  logic [33:0] rsp_exp;

  assign err_cnt_o = errors;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  function automatic periph_sel_e decode(input logic [31:0] addr);
    if (addr[31:12] != 20'h0) return SEL_NONE;
    case (addr[11:8])
      4'h0:    return SEL_SOC_CTRL;
      4'h1:    return SEL_FAST_INTR;
      4'h2:    return SEL_GPIO;
      4'h3:    return SEL_TIMER;
      default: return SEL_NONE;
    endcase
  endfunction

  // Reference model of a read: {mtime, err, rdata}
  function automatic logic [33:0] expected_read(input logic [31:0] addr);
    logic [31:0] data;
    logic        mtime;
    periph_sel_e sel;
    data  = '0;
    mtime = 1'b0;
    sel   = decode(addr);
    case (sel)
      SEL_SOC_CTRL: case (addr[7:2])
        SOC_EXIT_VALID: data = {31'b0, sh_exit_valid};
        SOC_EXIT_VALUE: data = sh_exit_value;
        SOC_BOOT_SEL:   data = {31'b0, boot_select_i};
        default:        data = '0;
      endcase
      SEL_FAST_INTR: case (addr[7:2])
        FI_PENDING: data = {17'b0, sh_pending};
        FI_ENABLE:  data = {17'b0, sh_fi_en};
        default:    data = '0;
      endcase
      SEL_GPIO: case (addr[7:2])
        GPIO_OUT:     data = {24'b0, sh_out};
        GPIO_EN:      data = {24'b0, sh_oe};
        GPIO_IN:      data = {24'b0, sync2};
        GPIO_INTR_EN: data = {24'b0, sh_intr_en};
        default:      data = '0;
      endcase
      SEL_TIMER: case (addr[7:2])
        TMR_MTIME: mtime = 1'b1;
        TMR_CMP:   data = sh_cmp;
        TMR_CTRL:  data = {31'b0, sh_tmr_en};
        default:   data = '0;
      endcase
      default: data = '0;
    endcase
    return {mtime, sel == SEL_NONE, data};
  endfunction

  task automatic apply_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
    logic [31:0] w;
    case (decode(addr))
      SEL_SOC_CTRL: begin
        if (addr[7:2] == SOC_EXIT_VALID && be[0]) sh_exit_valid = data[0];
        if (addr[7:2] == SOC_EXIT_VALUE) sh_exit_value = merge_bytes(sh_exit_value, data, be);
      end
      SEL_FAST_INTR: begin
        w = merge_bytes({17'b0, sh_fi_en}, data, be);
        if (addr[7:2] == FI_ENABLE) sh_fi_en = w[14:0];
        w = merge_bytes(32'h0, data, be);
        if (addr[7:2] == FI_PENDING) clr = w[14:0];
      end
      SEL_GPIO: begin
        w = merge_bytes({24'b0, sh_out}, data, be);
        if (addr[7:2] == GPIO_OUT) sh_out = w[7:0];
        w = merge_bytes({24'b0, sh_oe}, data, be);
        if (addr[7:2] == GPIO_EN) sh_oe = w[7:0];
        w = merge_bytes({24'b0, sh_intr_en}, data, be);
        if (addr[7:2] == GPIO_INTR_EN) sh_intr_en = w[7:0];
      end
      SEL_TIMER: begin
        if (addr[7:2] == TMR_CMP) sh_cmp = merge_bytes(sh_cmp, data, be);
        if (addr[7:2] == TMR_CTRL && be[0]) sh_tmr_en = data[0];
      end
      default: ;
    endcase
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error at %0t ns: %s expected 0x%h, actual 0x%h", $time, name, exp, act);
    errors++;
  endtask

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sh_exit_value = '0;
      sh_exit_valid = 1'b0;
      sh_pending    = '0;
      sh_fi_en      = '0;
      sh_out        = '0;
      sh_oe         = '0;
      sh_intr_en    = '0;
      sh_cmp        = '0;
      sh_tmr_en     = 1'b0;
      sync1         = '0;
      sync2         = '0;
      intr_seen     = 1'b0;
      rsp_pend      = 1'b0;
      rsp_we        = 1'b0;
      rsp_exp       = '0;
    end else begin
      if (rvalid_i !== rsp_pend) report_mismatch("rvalid_o", {31'b0, rsp_pend}, {31'b0, rvalid_i});
      if (rsp_pend) begin
        if (err_i !== rsp_exp[32]) report_mismatch("err_o", {31'b0, rsp_exp[32]}, {31'b0, err_i});
        if (rsp_exp[32] || (!rsp_we && !rsp_exp[33])) begin
          if (rdata_i !== rsp_exp[31:0]) report_mismatch("rdata_o", rsp_exp[31:0], rdata_i);
        end else if (!rsp_we && intr_seen && rdata_i < sh_cmp) begin
          report_mismatch("rdata_o (MTIME below CMP)", sh_cmp, rdata_i);
        end
      end
      if (gnt_i !== req_i) report_mismatch("gnt_o", {31'b0, req_i}, {31'b0, gnt_i});
      if (exit_value_i !== sh_exit_value) report_mismatch("exit_value_o", sh_exit_value, exit_value_i);
      if (exit_valid_i !== sh_exit_valid)
        report_mismatch("exit_valid_o", {31'b0, sh_exit_valid}, {31'b0, exit_valid_i});
      if (cio_gpio_out_i !== sh_out) report_mismatch("cio_gpio_o", {24'b0, sh_out}, {24'b0, cio_gpio_out_i});
      if (cio_gpio_en_i !== sh_oe) report_mismatch("cio_gpio_en_o", {24'b0, sh_oe}, {24'b0, cio_gpio_en_i});
      if (intr_gpio_i !== (sync2 & sh_intr_en))
        report_mismatch("intr_gpio_o", {24'b0, sync2 & sh_intr_en}, {24'b0, intr_gpio_i});
      if (fast_intr_out_i !== (sh_pending & sh_fi_en))
        report_mismatch("fast_intr_o", {17'b0, sh_pending & sh_fi_en}, {17'b0, fast_intr_out_i});
      if (!sh_tmr_en && timer_intr_i !== 1'b0) report_mismatch("timer_intr_o", 32'h0, {31'b0, timer_intr_i});
      if (timer_intr_i === 1'b1) intr_seen = 1'b1;

      clr      = '0;
      rsp_pend = req_i & gnt_i;
      rsp_we   = we_i;
      if (rsp_pend) begin
        rsp_exp = expected_read(addr_i);
        if (we_i) apply_write(addr_i, wdata_i, be_i);
      end
      // An incoming level wins over a clear
      sh_pending = (sh_pending & ~clr) | fast_intr_i;
      sync2      = sync1;
      sync1      = cio_gpio_i;
    end
  end

endmodule : tb_checker

`default_nettype wire

//--- verif/tb_ao_periph.sv
// Testbench for the always-on peripheral subsystem
// Drives bus traffic and pins, the monitor does the comparing

`default_nettype none

module tb_ao_periph
  import ao_periph_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic        clk, arst_n, req, we, gnt, rvalid, err;
  logic [31:0] addr, wdata, rdata, exit_value;
  logic [3:0]  be;
  logic        boot_select, exit_valid, timer_intr;
  logic [14:0] fast_intr_in, fast_intr_out;
  logic [7:0]  gpio_in, gpio_out, gpio_en, intr_gpio;
  logic [31:0] rw_regs [7];
  int          err_cnt;
  int          timeouts = 0;
  int          seed;

  ao_periph_subsys i_dut (
    .clk_i(clk), .arst_n_i(arst_n),
    .req_i(req), .addr_i(addr), .we_i(we), .be_i(be), .wdata_i(wdata),
    .gnt_o(gnt), .rvalid_o(rvalid), .rdata_o(rdata), .err_o(err),
    .boot_select_i(boot_select), .exit_valid_o(exit_valid), .exit_value_o(exit_value),
    .fast_intr_i(fast_intr_in), .fast_intr_o(fast_intr_out),
    .cio_gpio_i(gpio_in), .cio_gpio_o(gpio_out), .cio_gpio_en_o(gpio_en),
    .intr_gpio_o(intr_gpio), .timer_intr_o(timer_intr)
  );

  tb_checker i_checker (
    .clk_i(clk), .arst_n_i(arst_n),
    .req_i(req), .addr_i(addr), .we_i(we), .be_i(be), .wdata_i(wdata),
    .gnt_i(gnt), .rvalid_i(rvalid), .rdata_i(rdata), .err_i(err),
    .boot_select_i(boot_select), .exit_valid_i(exit_valid), .exit_value_i(exit_value),
    .fast_intr_i(fast_intr_in), .fast_intr_out_i(fast_intr_out),
    .cio_gpio_i(gpio_in), .cio_gpio_out_i(gpio_out), .cio_gpio_en_i(gpio_en),
    .intr_gpio_i(intr_gpio), .timer_intr_i(timer_intr), .err_cnt_o(err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [5:0] offs);
    return base + {24'h0, offs, 2'b00};
  endfunction

  // Issues one request at the current edge and returns at the edge that grants it
  task automatic bus_access(input logic [31:0] a, input logic w, input logic [3:0] b,
                            input logic [31:0] d);
    int n;
    req   <= 1'b1;
    addr  <= a;
    we    <= w;
    be    <= b;
    wdata <= d;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (gnt !== 1'b1 && n < 20);
    if (gnt !== 1'b1) begin
      $display("Request to address 0x%h was never granted", a);
      timeouts++;
    end
  endtask

  task automatic bus_idle(input int cycles);
    req <= 1'b0;
    we  <= 1'b0;
    repeat (cycles) @(posedge clk);
  endtask

  task automatic end_run();
    $display("Run complete: %0d errors, %0d timeouts", err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  initial begin
    int          n;
    logic [31:0] rnd;
    logic [31:0] rnd_be;
    seed         = 3;
    arst_n       = 1'b0;
    req          = 1'b0;
    addr         = '0;
    we           = 1'b0;
    be           = '0;
    wdata        = '0;
    boot_select  = 1'b0;
    fast_intr_in = '0;
    gpio_in      = '0;
    rw_regs[0] = reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALUE);
    rw_regs[1] = reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALID);
    rw_regs[2] = reg_addr(GPIO_BASE, GPIO_OUT);
    rw_regs[3] = reg_addr(GPIO_BASE, GPIO_EN);
    rw_regs[4] = reg_addr(GPIO_BASE, GPIO_INTR_EN);
    rw_regs[5] = reg_addr(FAST_INTR_BASE, FI_ENABLE);
    rw_regs[6] = reg_addr(TIMER_BASE, TMR_CMP);
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // Full and partial writes, then back-to-back reads
    foreach (rw_regs[i]) begin
      bus_access(rw_regs[i], 1'b1, 4'hf, $random(seed));
      rnd_be = $random(seed);
      bus_access(rw_regs[i], 1'b1, rnd_be[3:0], $random(seed));
    end
    foreach (rw_regs[i]) bus_access(rw_regs[i], 1'b0, 4'hf, 32'h0);
    bus_idle(1);

    // GPIO input through the synchroniser, boot select status
    rnd = $random(seed);
    gpio_in     <= rnd[7:0];
    boot_select <= 1'b1;
    bus_idle(3);
    bus_access(reg_addr(GPIO_BASE, GPIO_IN), 1'b0, 4'hf, 32'h0);
    bus_access(reg_addr(SOC_CTRL_BASE, SOC_BOOT_SEL), 1'b0, 4'hf, 32'h0);
    bus_idle(1);

    // Fast interrupt pulses, then write-one-to-clear
    repeat (3) begin
      rnd = $random(seed);
      fast_intr_in <= rnd[14:0];
      @(posedge clk);
    end
    fast_intr_in <= '0;
    bus_idle(1);
    bus_access(reg_addr(FAST_INTR_BASE, FI_PENDING), 1'b0, 4'hf, 32'h0);
    bus_access(reg_addr(FAST_INTR_BASE, FI_PENDING), 1'b1, 4'h1, $random(seed));
    bus_access(reg_addr(FAST_INTR_BASE, FI_PENDING), 1'b0, 4'hf, 32'h0);
    bus_access(reg_addr(FAST_INTR_BASE, FI_PENDING), 1'b1, 4'hf, 32'h0000_7fff);
    bus_access(reg_addr(FAST_INTR_BASE, FI_PENDING), 1'b0, 4'hf, 32'h0);
    bus_idle(1);

    // Timer compare interrupt
    bus_access(reg_addr(TIMER_BASE, TMR_CMP), 1'b1, 4'hf, 32'd20);
    bus_access(reg_addr(TIMER_BASE, TMR_CTRL), 1'b1, 4'hf, 32'd1);
    bus_idle(1);
    n = 0;
    while (timer_intr !== 1'b1 && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (timer_intr !== 1'b1) begin
      $display("Timer interrupt did not fire within 200 cycles");
      timeouts++;
    end
    bus_access(reg_addr(TIMER_BASE, TMR_MTIME), 1'b0, 4'hf, 32'h0);
    bus_access(reg_addr(TIMER_BASE, TMR_CTRL), 1'b1, 4'hf, 32'd0);
    bus_idle(1);
    n = 0;
    while (timer_intr !== 1'b0 && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (timer_intr !== 1'b0) begin
      $display("Timer interrupt stayed high after the timer was disabled");
      timeouts++;
    end
    bus_access(reg_addr(TIMER_BASE, TMR_MTIME), 1'b0, 4'hf, 32'h0);

    // Unmapped addresses, then confirm nothing moved
    bus_access(32'h0000_0400, 1'b1, 4'hf, $random(seed));
    bus_access(32'h0000_0f04, 1'b0, 4'hf, 32'h0);
    bus_access(32'h8000_0200, 1'b1, 4'hf, $random(seed));
    bus_access(32'h0001_0000, 1'b0, 4'hf, 32'h0);
    foreach (rw_regs[i]) bus_access(rw_regs[i], 1'b0, 4'hf, 32'h0);
    bus_idle(3);
    end_run();
  end

endmodule : tb_ao_periph

`default_nettype wire

//--- files.f
common/ao_periph_pkg.sv
hw/periph_bus_ctrl/periph_bus_ctrl.sv
hw/soc_ctrl/soc_ctrl.sv
hw/fast_intr_ctrl/fast_intr_ctrl.sv
hw/gpio/gpio.sv
hw/timer/timer.sv
hw/ao_periph_subsys.sv
verif/tb_checker.sv
verif/tb_ao_periph.sv
